// File: vst_pkg.sv
package vst_pkg;

  // Datapath geometry
  localparam int unsigned NrLanes      = 2;
  localparam int unsigned ElenBits     = 64;
  localparam int unsigned LaneBytes    = ElenBits / 8;
  localparam int unsigned BeatBytes    = NrLanes * LaneBytes;
  localparam int unsigned BeatIdxWidth = $clog2(BeatBytes);

  // Burst shape on AW and W
  localparam int unsigned MaxBurstBeats = 4;
  localparam int unsigned BurstBytes    = BeatBytes * MaxBurstBeats;
  localparam int unsigned LenWidth      = 8;

  // Instruction queue and id space
  localparam int unsigned InsnQueueDepth = 4;
  localparam int unsigned QPtrWidth      = $clog2(InsnQueueDepth);
  localparam int unsigned QCntWidth      = QPtrWidth + 1;
  localparam int unsigned NrVInsn        = 8;

  // Address and length fields
  localparam int unsigned AddrWidth     = 32;
  localparam int unsigned VlWidth       = 9;
  // Byte count of the widest store, vl of EW64 elements
  localparam int unsigned ByteCntWidth  = VlWidth + 3;
  localparam int unsigned BeatCntWidth  = ByteCntWidth - BeatIdxWidth + 1;
  localparam int unsigned BurstCntWidth = ByteCntWidth - $clog2(BurstBytes) + 1;

  // Element width, value is the byte shift
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } ew_e;

  typedef logic [$clog2(NrVInsn)-1:0] insn_id_t;

  // Store instruction, vm set means unmasked
  typedef struct packed {
    insn_id_t             id;
    logic [AddrWidth-1:0] addr;
    logic [VlWidth-1:0]   vl;
    ew_e                  ew;
    logic                 vm;
  } vst_insn_t;

  // Total bytes written by one instruction
  function automatic logic [ByteCntWidth-1:0] store_bytes(vst_insn_t insn);
    return ByteCntWidth'(insn.vl) << insn.ew;
  endfunction

  // Bursts of up to BurstBytes needed for one instruction
  function automatic logic [BurstCntWidth-1:0] nr_bursts(vst_insn_t insn);
    logic [ByteCntWidth:0] bytes_rnd;
    bytes_rnd = {1'b0, store_bytes(insn)} + (ByteCntWidth + 1)'(BurstBytes - 1);
    return BurstCntWidth'(bytes_rnd >> $clog2(BurstBytes));
  endfunction

  // Sequential beat byte to lane byte, element e sits in lane e mod NrLanes
  function automatic logic [BeatIdxWidth-1:0] shuffle_index(logic [BeatIdxWidth-1:0] seq_byte,
                                                            ew_e ew);
    int unsigned elem;
    int unsigned lane;
    int unsigned offset;
    elem   = int'(seq_byte) >> ew;
    lane   = elem % NrLanes;
    offset = ((elem / NrLanes) << ew) + (int'(seq_byte) & ((1 << ew) - 1));
    return BeatIdxWidth'(lane * LaneBytes + offset);
  endfunction

endpackage

// File: vst_burst_if.sv
interface vst_burst_if import vst_pkg::*; ();

  // AXI style length of the burst, beats minus one
  logic [LenWidth-1:0] len;
  // Final burst of its instruction
  logic                last;
  logic                valid;
  logic                ready;

  // Producer side, pushed together with the AW handshake
  modport addrgen (
    output len,
    output last,
    output valid,
    input  ready
  );

  // Consumer side, popped on the last W beat of the burst
  modport packer (
    input  len,
    input  last,
    input  valid,
    output ready
  );

endinterface

// File: vst_insn_queue.sv
module vst_insn_queue import vst_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Instruction input, four-phase req/ack
  input  logic      insn_req_i,
  input  vst_insn_t insn_i,
  output logic      insn_ack_o,
  // Oldest instruction not yet issued
  output vst_insn_t issue_insn_o,
  output logic      issue_valid_o,
  input  logic      issue_done_i,
  // B channel
  input  logic      b_valid_i,
  output logic      b_ready_o,
  // Completion report
  output logic      done_o,
  output insn_id_t  done_id_o,
  output logic      store_pending_o
);

  // Instruction storage
  vst_insn_t queue_q [InsnQueueDepth];

  // Accept, issue and commit pointers
  logic [QPtrWidth-1:0] accept_pnt_q;
  logic [QPtrWidth-1:0] issue_pnt_q;
  logic [QPtrWidth-1:0] commit_pnt_q;

  // Entries waiting to be issued and waiting for their B responses
  logic [QCntWidth-1:0] issue_cnt_q;
  logic [QCntWidth-1:0] commit_cnt_q;

  // B responses collected for the commit entry
  logic [BurstCntWidth-1:0] b_cnt_q;

  // One bit per id, set from accept until done
  logic [NrVInsn-1:0] running_q;
  logic [NrVInsn-1:0] running_set;
  logic [NrVInsn-1:0] running_clr;

  logic      ack_q;
  logic      done_q;
  insn_id_t  done_id_q;
  vst_insn_t commit_insn;
  logic      full;
  logic      accept;
  logic      b_hs;
  logic      commit;

  assign full        = (commit_cnt_q == QCntWidth'(InsnQueueDepth));
  assign commit_insn = queue_q[commit_pnt_q];

  // Take a request only while ack is low, with room and a free id
  assign accept = insn_req_i && !ack_q && !full && !running_q[insn_i.id];

  // Any entry past issue can receive B
  assign b_ready_o = (commit_cnt_q != '0);
  assign b_hs      = b_valid_i && b_ready_o;

  // Last B of the commit entry retires it
  assign commit = b_hs && (BurstCntWidth'(b_cnt_q + 1'b1) == nr_bursts(commit_insn));

  assign running_set = accept ? (NrVInsn'(1) << insn_i.id) : '0;
  assign running_clr = commit ? (NrVInsn'(1) << commit_insn.id) : '0;

  assign issue_insn_o    = queue_q[issue_pnt_q];
  assign issue_valid_o   = (issue_cnt_q != '0);
  assign insn_ack_o      = ack_q;
  assign done_o          = done_q;
  assign done_id_o       = done_id_q;
  assign store_pending_o = (commit_cnt_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      b_cnt_q      <= '0;
      running_q    <= '0;
      ack_q        <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      // Pointers wrap naturally, depth is a power of two
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      if (issue_done_i) begin
        issue_pnt_q <= issue_pnt_q + 1'b1;
      end
      if (commit) begin
        commit_pnt_q <= commit_pnt_q + 1'b1;
      end
      issue_cnt_q  <= issue_cnt_q + QCntWidth'(accept) - QCntWidth'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + QCntWidth'(accept) - QCntWidth'(commit);
      if (b_hs) begin
        b_cnt_q <= commit ? '0 : b_cnt_q + 1'b1;
      end
      running_q <= (running_q & ~running_clr) | running_set;
      // Ack rises after accept, falls once req is gone
      if (accept) begin
        ack_q <= 1'b1;
      end else if (!insn_req_i) begin
        ack_q <= 1'b0;
      end
      done_q <= commit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      queue_q[accept_pnt_q] <= insn_i;
    end
    if (commit) begin
      done_id_q <= commit_insn.id;
    end
  end

endmodule

// File: vst_addrgen.sv
module vst_addrgen import vst_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Issue entry of the queue
  input  vst_insn_t            issue_insn_i,
  input  logic                 issue_valid_i,
  // AW channel
  output logic [AddrWidth-1:0] aw_addr_o,
  output logic [LenWidth-1:0]  aw_len_o,
  output logic                 aw_valid_o,
  input  logic                 aw_ready_i,
  // Descriptor towards the packer
  vst_burst_if.addrgen         burst
);

  // Walk state of the current instruction
  logic                    running_q;
  logic [AddrWidth-1:0]    addr_q;
  logic [BeatCntWidth-1:0] beats_left_q;

  // Set after the final burst until the issue entry moves on
  logic     wait_q;
  insn_id_t last_id_q;

  // Descriptor held for the packer
  logic                desc_valid_q;
  logic [LenWidth-1:0] desc_len_q;
  logic                desc_last_q;

  logic [ByteCntWidth:0]   bytes_rnd;
  logic [BeatCntWidth-1:0] beats_total;
  logic [BeatCntWidth-1:0] burst_beats;
  logic                    final_burst;
  logic                    start;
  logic                    aw_hs;

  // Beats of the issue entry, rounded up to whole beats
  assign bytes_rnd   = {1'b0, store_bytes(issue_insn_i)} + (ByteCntWidth + 1)'(BeatBytes - 1);
  assign beats_total = BeatCntWidth'(bytes_rnd >> BeatIdxWidth);

  // Same id still at issue means the old entry has not retired yet
  assign start = !running_q && issue_valid_i && !(wait_q && issue_insn_i.id == last_id_q);

  assign final_burst = (beats_left_q <= BeatCntWidth'(MaxBurstBeats));
  assign burst_beats = final_burst ? beats_left_q : BeatCntWidth'(MaxBurstBeats);

  // Next AW waits until the packer pops the previous descriptor
  assign aw_valid_o = running_q && !desc_valid_q;
  assign aw_addr_o  = addr_q;
  assign aw_len_o   = LenWidth'(burst_beats - 1'b1);
  assign aw_hs      = aw_valid_o && aw_ready_i;

  assign burst.valid = desc_valid_q;
  assign burst.len   = desc_len_q;
  assign burst.last  = desc_last_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q    <= 1'b0;
      wait_q       <= 1'b0;
      desc_valid_q <= 1'b0;
    end else begin
      if (start) begin
        running_q <= 1'b1;
      end else if (aw_hs && final_burst) begin
        running_q <= 1'b0;
      end
      if (start || !issue_valid_i) begin
        wait_q <= 1'b0;
      end else if (aw_hs && final_burst) begin
        wait_q <= 1'b1;
      end
      // Push with AW, pop on the last W beat
      if (aw_hs) begin
        desc_valid_q <= 1'b1;
      end else if (burst.ready) begin
        desc_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      addr_q       <= issue_insn_i.addr;
      beats_left_q <= beats_total;
      last_id_q    <= issue_insn_i.id;
    end else if (aw_hs) begin
      addr_q       <= addr_q + AddrWidth'(BurstBytes);
      beats_left_q <= beats_left_q - burst_beats;
    end
    if (aw_hs) begin
      desc_len_q  <= aw_len_o;
      desc_last_q <= final_burst;
    end
  end

endmodule

// File: vst_beat_packer.sv
module vst_beat_packer import vst_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Issue entry of the queue
  input  vst_insn_t                           issue_insn_i,
  input  logic                                issue_valid_i,
  output logic                                issue_done_o,
  // Descriptor from the address generator
  vst_burst_if.packer                         burst,
  // Lane operands with the mask that travels with each word
  input  logic [NrLanes-1:0][ElenBits-1:0]    operand_i,
  input  logic [BeatBytes-1:0]                mask_i,
  input  logic                                operand_valid_i,
  output logic                                operand_ready_o,
  // W channel
  output logic [BeatBytes*8-1:0]              w_data_o,
  output logic [BeatBytes-1:0]                w_strb_o,
  output logic                                w_last_o,
  output logic                                w_valid_o,
  input  logic                                w_ready_i
);

  // Beat index inside the current burst
  logic [LenWidth-1:0] beat_q;

  // Bytes already sent for the issue entry
  logic [ByteCntWidth-1:0] byte_pnt_q;
  logic [ByteCntWidth-1:0] bytes_left;

  // Lane words flattened with lane 0 in the low bytes
  logic [BeatBytes*8-1:0] operand_flat;

  // Lane byte feeding each sequential beat byte
  logic [BeatBytes-1:0][BeatIdxWidth-1:0] lane_byte;

  logic w_hs;

  assign operand_flat = operand_i;
  assign bytes_left   = store_bytes(issue_insn_i) - byte_pnt_q;

  // Gather bytes back into memory order
  for (genvar b = 0; b < BeatBytes; b++) begin : gen_beat_bytes
    assign lane_byte[b] = shuffle_index(BeatIdxWidth'(b), issue_insn_i.ew);
    assign w_data_o[8*b +: 8] = operand_flat[8*lane_byte[b] +: 8];
    // Tail bytes past the instruction end stay disabled
    assign w_strb_o[b] = (ByteCntWidth'(b) < bytes_left) &&
                         (issue_insn_i.vm || mask_i[lane_byte[b]]);
  end

  // A beat needs both an operand word and an open burst
  assign w_valid_o = operand_valid_i && burst.valid && issue_valid_i;
  // Last marks only a presented beat
  assign w_last_o  = w_valid_o && (beat_q == burst.len);
  assign w_hs      = w_valid_o && w_ready_i;

  // W back-pressure holds the operand word in place
  assign operand_ready_o = w_hs;

  // Last beat of a burst frees the descriptor
  assign burst.ready = w_hs && w_last_o;

  // Last beat of the final burst ends the issue phase
  assign issue_done_o = w_hs && w_last_o && burst.last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_q     <= '0;
      byte_pnt_q <= '0;
    end else if (w_hs) begin
      if (w_last_o) begin
        beat_q <= '0;
      end else begin
        beat_q <= beat_q + 1'b1;
      end
      // Restart the byte count for the next entry
      if (issue_done_o) begin
        byte_pnt_q <= '0;
      end else begin
        byte_pnt_q <= byte_pnt_q + ByteCntWidth'(BeatBytes);
      end
    end
  end

endmodule

// File: vst_top.sv
module vst_top import vst_pkg::*; (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Instruction input
  input  logic                             insn_req_i,
  input  vst_insn_t                        insn_i,
  output logic                             insn_ack_o,
  // AW channel
  output logic [AddrWidth-1:0]             aw_addr_o,
  output logic [LenWidth-1:0]              aw_len_o,
  output logic                             aw_valid_o,
  input  logic                             aw_ready_i,
  // W channel
  output logic [BeatBytes*8-1:0]           w_data_o,
  output logic [BeatBytes-1:0]             w_strb_o,
  output logic                             w_last_o,
  output logic                             w_valid_o,
  input  logic                             w_ready_i,
  // B channel
  input  logic                             b_valid_i,
  output logic                             b_ready_o,
  // Lane operands
  input  logic [NrLanes-1:0][ElenBits-1:0] operand_i,
  input  logic [BeatBytes-1:0]             mask_i,
  input  logic                             operand_valid_i,
  output logic                             operand_ready_o,
  // Status
  output logic                             done_o,
  output insn_id_t                         done_id_o,
  output logic                             store_pending_o
);

  // Issue entry shared by the generator and the packer
  vst_insn_t issue_insn;
  logic      issue_valid;
  logic      issue_done;

  // One descriptor in flight between AW and W
  vst_burst_if i_burst_if ();

  vst_insn_queue i_insn_queue (
    .clk_i,
    .rst_ni,
    .insn_req_i,
    .insn_i,
    .insn_ack_o,
    .issue_insn_o  (issue_insn),
    .issue_valid_o (issue_valid),
    .issue_done_i  (issue_done),
    .b_valid_i,
    .b_ready_o,
    .done_o,
    .done_id_o,
    .store_pending_o
  );

  vst_addrgen i_addrgen (
    .clk_i,
    .rst_ni,
    .issue_insn_i  (issue_insn),
    .issue_valid_i (issue_valid),
    .aw_addr_o,
    .aw_len_o,
    .aw_valid_o,
    .aw_ready_i,
    .burst         (i_burst_if.addrgen)
  );

  vst_beat_packer i_beat_packer (
    .clk_i,
    .rst_ni,
    .issue_insn_i  (issue_insn),
    .issue_valid_i (issue_valid),
    .issue_done_o  (issue_done),
    .burst         (i_burst_if.packer),
    .operand_i,
    .mask_i,
    .operand_valid_i,
    .operand_ready_o,
    .w_data_o,
    .w_strb_o,
    .w_last_o,
    .w_valid_o,
    .w_ready_i
  );

endmodule

// File: tb_vst_assert.sv
module tb_vst_assert import vst_pkg::*; (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   insn_req_i,
  input logic                   insn_ack_o,
  input logic [AddrWidth-1:0]   aw_addr_o,
  input logic [LenWidth-1:0]    aw_len_o,
  input logic                   aw_valid_o,
  input logic                   aw_ready_i,
  input logic [BeatBytes*8-1:0] w_data_o,
  input logic [BeatBytes-1:0]   w_strb_o,
  input logic                   w_last_o,
  input logic                   w_valid_o,
  input logic                   w_ready_i,
  input logic                   done_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // AW payload held until accepted
  aw_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o) && $stable(aw_len_o))
    else $error("AW payload changed under back-pressure");

  // W payload held until accepted
  w_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o) && $stable(w_strb_o)
      && $stable(w_last_o))
    else $error("W payload changed under back-pressure");

  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(insn_ack_o) |-> $past(insn_req_i))
    else $error("Ack rose without a request");

  done_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |=> !done_o)
    else $error("Done high for two cycles");

  // Last appears only on a valid beat
  last_with_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_last_o |-> w_valid_o)
    else $error("Last high without a valid W beat");

endmodule

bind vst_top tb_vst_assert i_assert (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .insn_req_i (insn_req_i),
  .insn_ack_o (insn_ack_o),
  .aw_addr_o  (aw_addr_o),
  .aw_len_o   (aw_len_o),
  .aw_valid_o (aw_valid_o),
  .aw_ready_i (aw_ready_i),
  .w_data_o   (w_data_o),
  .w_strb_o   (w_strb_o),
  .w_last_o   (w_last_o),
  .w_valid_o  (w_valid_o),
  .w_ready_i  (w_ready_i),
  .done_o     (done_o)
);

// File: tb_vst_top.sv
module tb_vst_top import vst_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned MemBytes = 4096;
  localparam int unsigned Timeout  = 3000;

  logic                             clk_i;
  logic                             rst_ni;
  logic                             insn_req_i;
  vst_insn_t                        insn_i;
  logic                             insn_ack_o;
  logic [AddrWidth-1:0]             aw_addr_o;
  logic [LenWidth-1:0]              aw_len_o;
  logic                             aw_valid_o;
  logic                             aw_ready_i;
  logic [BeatBytes*8-1:0]           w_data_o;
  logic [BeatBytes-1:0]             w_strb_o;
  logic                             w_last_o;
  logic                             w_valid_o;
  logic                             w_ready_i;
  logic                             b_valid_i;
  logic                             b_ready_o;
  logic [NrLanes-1:0][ElenBits-1:0] operand_i;
  logic [BeatBytes-1:0]             mask_i;
  logic                             operand_valid_i;
  logic                             operand_ready_o;
  logic                             done_o;
  insn_id_t                         done_id_o;
  logic                             store_pending_o;

  // Memory image seen by the bus and the one predicted from the stimulus
  logic [7:0] mem     [MemBytes];
  logic [7:0] exp_mem [MemBytes];

  // Operand beats waiting for the DUT
  logic [BeatBytes*8-1:0] op_data_q [$];
  logic [BeatBytes-1:0]   op_mask_q [$];

  // Open AW bursts and the AW history of a test
  logic [AddrWidth-1:0] aw_addr_q [$];
  logic [LenWidth-1:0]  aw_len_q  [$];
  logic [AddrWidth-1:0] aw_log_addr [$];
  logic [LenWidth-1:0]  aw_log_len  [$];

  insn_id_t    got_done_q [$];
  insn_id_t    exp_done_q [$];
  int unsigned b_owed;
  int unsigned b_count;
  int unsigned done_bcnt;
  int unsigned strb_count;
  int unsigned mismatches;
  int unsigned other_errors;
  logic        bp_on;
  logic        b_hold;

  vst_top i_dut (.*);

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  task automatic check_value(input string msg, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  task automatic stop_on_timeout(input string msg);
    $display("Timeout at %0t: %s", $time, msg);
    $display("Errors: %0d mismatches, %0d other", mismatches, other_errors + 1);
    $display("Simulation failed");
    $finish;
  endtask

  function automatic vst_insn_t make_insn(int unsigned id, int unsigned addr, int unsigned vl,
                                          ew_e ew, logic vm);
    vst_insn_t insn;
    insn.id   = insn_id_t'(id);
    insn.addr = AddrWidth'(addr);
    insn.vl   = VlWidth'(vl);
    insn.ew   = ew;
    insn.vm   = vm;
    return insn;
  endfunction

  // Random beats for one store and the memory bytes they must produce
  task automatic expect_insn(input vst_insn_t insn);
    int unsigned ew;
    int unsigned bytes;
    int unsigned beats;
    int unsigned idx;
    int unsigned elem;
    int unsigned lbyte;
    logic [BeatBytes*8-1:0] data;
    logic [BeatBytes-1:0]   mask;
    ew    = int'(insn.ew);
    bytes = int'(insn.vl) << ew;
    beats = (bytes + BeatBytes - 1) / BeatBytes;
    for (int unsigned k = 0; k < beats; k++) begin
      data = {$urandom(), $urandom(), $urandom(), $urandom()};
      mask = BeatBytes'($urandom());
      for (int unsigned b = 0; b < BeatBytes; b++) begin
        idx   = k * BeatBytes + b;
        elem  = b >> ew;
        // Element e sits in lane e mod 2 and packs upwards inside the lane
        lbyte = (elem % NrLanes) * LaneBytes + ((elem / NrLanes) << ew) + (b % (1 << ew));
        if (idx < bytes && (insn.vm || mask[lbyte])) begin
          exp_mem[(int'(insn.addr) + idx) % MemBytes] = data[8*lbyte +: 8];
        end
      end
      op_data_q.push_back(data);
      op_mask_q.push_back(mask);
    end
    exp_done_q.push_back(insn.id);
  endtask

  task automatic raise_req(input vst_insn_t insn);
    @(negedge clk_i);
    insn_i     = insn;
    insn_req_i = 1'b1;
  endtask

  // Wait for ack, drop req, wait for ack to fall
  task automatic finish_req();
    int unsigned n;
    n = 0;
    while (!insn_ack_o) begin
      @(negedge clk_i);
      if (++n > Timeout) stop_on_timeout("instruction ack never rose");
    end
    insn_req_i = 1'b0;
    n = 0;
    while (insn_ack_o) begin
      @(negedge clk_i);
      if (++n > Timeout) stop_on_timeout("instruction ack never fell");
    end
  endtask

  task automatic send_insn(input vst_insn_t insn);
    expect_insn(insn);
    raise_req(insn);
    finish_req();
  endtask

  // Request stays unanswered for a number of cycles
  task automatic expect_no_ack(input int unsigned cycles, input string msg);
    repeat (cycles) begin
      @(negedge clk_i);
      if (insn_ack_o) begin
        other_errors++;
        $display("Error at %0t: %s", $time, msg);
      end
    end
  endtask

  task automatic wait_done(input int unsigned count);
    int unsigned n;
    n = 0;
    while (got_done_q.size() < count) begin
      @(negedge clk_i);
      if (!store_pending_o && got_done_q.size() + int'(done_o) < count) begin
        other_errors++;
        $display("Error at %0t: store pending dropped before the last done", $time);
      end
      if (++n > Timeout) stop_on_timeout("done never reported");
    end
  endtask

  // Done ids in acceptance order and the full memory image
  task automatic check_results();
    check_value("done count", got_done_q.size(), exp_done_q.size());
    for (int i = 0; i < exp_done_q.size() && i < got_done_q.size(); i++) begin
      check_value($sformatf("done id %0d", i), got_done_q[i], exp_done_q[i]);
    end
    for (int unsigned a = 0; a < MemBytes; a++) begin
      check_value($sformatf("memory byte %0h", a), mem[a], exp_mem[a]);
    end
    got_done_q.delete();
    exp_done_q.delete();
    aw_log_addr.delete();
    aw_log_len.delete();
  endtask

  task automatic unmasked_ew64();
    send_insn(make_insn(1, 'h000, 8, EW64, 1'b1));
    wait_done(1);
    check_value("aw count", aw_log_len.size(), 1);
    check_value("aw len", aw_log_len[0], 3);
    check_results();
  endtask

  task automatic ew8_tail();
    strb_count = 0;
    send_insn(make_insn(2, 'h100, 37, EW8, 1'b1));
    wait_done(1);
    check_value("strobe bytes", strb_count, 37);
    check_value("aw len", aw_log_len[0], 2);
    check_results();
  endtask

  task automatic masked_ew32();
    send_insn(make_insn(3, 'h200, 8, EW32, 1'b0));
    wait_done(1);
    check_results();
  endtask

  task automatic long_ew64();
    int unsigned b_start;
    b_start = b_count;
    send_insn(make_insn(4, 'h300, 40, EW64, 1'b1));
    wait_done(1);
    check_value("aw count", aw_log_addr.size(), 5);
    for (int i = 0; i < aw_log_addr.size(); i++) begin
      check_value($sformatf("aw addr %0d", i), aw_log_addr[i], 'h300 + 64 * i);
      check_value($sformatf("aw len %0d", i), aw_log_len[i], 3);
    end
    check_value("B before done", done_bcnt - b_start, 5);
    check_results();
  endtask

  task automatic full_queue();
    vst_insn_t fifth;
    bp_on  = 1'b1;
    b_hold = 1'b1;
    for (int unsigned i = 0; i < InsnQueueDepth; i++) begin
      send_insn(make_insn(i, 'h500 + i * 'h140, 40, EW64, 1'b1));
    end
    fifth = make_insn(4, 'hA00, 8, EW64, 1'b1);
    expect_insn(fifth);
    raise_req(fifth);
    expect_no_ack(30, "fifth instruction acked while the queue is full");
    b_hold = 1'b0;
    finish_req();
    if (got_done_q.size() == 0) begin
      other_errors++;
      $display("Error at %0t: fifth instruction accepted before any done", $time);
    end
    wait_done(5);
    check_results();
    bp_on = 1'b0;
  endtask

  task automatic duplicate_id();
    vst_insn_t dup;
    b_hold = 1'b1;
    send_insn(make_insn(5, 'hB00, 16, EW64, 1'b1));
    dup = make_insn(5, 'hC00, 8, EW32, 1'b1);
    expect_insn(dup);
    raise_req(dup);
    expect_no_ack(20, "duplicate id acked while still running");
    b_hold = 1'b0;
    finish_req();
    check_value("done before duplicate", got_done_q.size() >= 1, 1);
    wait_done(2);
    check_results();
  endtask

  // AW, W and B side of memory sampled after inputs settle
  initial begin : mem_model
    int unsigned beat;
    int unsigned b_delay;
    logic [AddrWidth-1:0] base;
    beat    = 0;
    b_delay = 1;
    forever begin
      @(negedge clk_i);
      aw_ready_i = bp_on ? 1'($urandom_range(1, 0)) : 1'b1;
      w_ready_i  = bp_on ? 1'($urandom_range(1, 0)) : 1'b1;
      if (b_delay != 0) b_delay--;
      b_valid_i = (b_owed != 0) && (b_delay == 0) && !b_hold;
      #1;
      if (aw_valid_o && aw_ready_i) begin
        aw_addr_q.push_back(aw_addr_o);
        aw_len_q.push_back(aw_len_o);
        aw_log_addr.push_back(aw_addr_o);
        aw_log_len.push_back(aw_len_o);
      end
      if (w_valid_o && w_ready_i) begin
        if (aw_addr_q.size() == 0) begin
          other_errors++;
          $display("Error at %0t: W beat without an open AW burst", $time);
        end else begin
          base = aw_addr_q[0] + AddrWidth'(beat * BeatBytes);
          for (int unsigned b = 0; b < BeatBytes; b++) begin
            if (w_strb_o[b]) begin
              mem[(int'(base) + b) % MemBytes] = w_data_o[8*b +: 8];
              strb_count++;
            end
          end
          check_value("w_last", w_last_o, beat == int'(aw_len_q[0]));
          if (beat == int'(aw_len_q[0])) begin
            void'(aw_addr_q.pop_front());
            void'(aw_len_q.pop_front());
            beat = 0;
            b_owed++;
          end else begin
            beat++;
          end
        end
      end
      // B never valid in two cycles back to back
      if (b_valid_i && b_ready_o) begin
        b_owed--;
        b_count++;
        b_delay = 2 + $urandom_range(bp_on ? 7 : 2, 0);
      end
      if (done_o) begin
        got_done_q.push_back(done_id_o);
        done_bcnt = b_count;
      end
    end
  end

  // Presents queued operand beats and advances after each handshake
  initial begin : operand_driver
    logic hs;
    hs = 1'b0;
    forever begin
      @(negedge clk_i);
      if (hs) begin
        void'(op_data_q.pop_front());
        void'(op_mask_q.pop_front());
      end
      operand_valid_i = (op_data_q.size() != 0);
      if (operand_valid_i) begin
        operand_i = op_data_q[0];
        mask_i    = op_mask_q[0];
      end
      #1;
      hs = operand_valid_i && operand_ready_o;
    end
  end

  initial begin
    void'($urandom(39));
    rst_ni = 1'b0;
    insn_req_i = 1'b0;
    insn_i = '0;
    aw_ready_i = 1'b0;
    w_ready_i = 1'b0;
    b_valid_i = 1'b0;
    operand_i = '0;
    mask_i = '0;
    operand_valid_i = 1'b0;
    {b_owed, b_count, done_bcnt, strb_count, mismatches, other_errors} = '0;
    bp_on  = 1'b0;
    b_hold = 1'b0;
    // Preset pattern over all address bits
    for (int unsigned a = 0; a < MemBytes; a++) begin
      mem[a]     = 8'(a ^ (a >> 4) ^ (a >> 8)) ^ 8'hA5;
      exp_mem[a] = mem[a];
    end
    repeat (10) @(negedge clk_i);
    // Handshake and status outputs idle out of reset
    check_value("ack after reset", insn_ack_o, 0);
    check_value("aw valid after reset", aw_valid_o, 0);
    check_value("w valid after reset", w_valid_o, 0);
    check_value("b ready after reset", b_ready_o, 0);
    check_value("done after reset", done_o, 0);
    rst_ni = 1'b1;
    unmasked_ew64();
    ew8_tail();
    masked_ew32();
    long_ew64();
    full_queue();
    duplicate_id();
    $display("Errors: %0d mismatches, %0d other", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: src.f
vst_pkg.sv
vst_burst_if.sv
vst_insn_queue.sv
vst_addrgen.sv
vst_beat_packer.sv
vst_top.sv
tb_vst_assert.sv
tb_vst_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vst_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
	  echo "Run failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Simulation passed" $(LOG); then \
	  echo "Run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
